/* sources.f */
hw/erx_pkg.sv
hw/erx_fifo.sv
hw/erx_arbiter.sv
hw/erx_cfg.sv
hw/erx_mailbox.sv
hw/erx_core.sv
verif/tb_erx_core.sv

/* Makefile */
# Verilator build and run for the erx receive core

VERILATOR ?= verilator
TOP       ?= tb_erx_core
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, not the exit code of the binary
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/erx_vectors.txt */
# Record: tag then packet hex as srcaddr data dstaddr and low byte {ctrlmode,datamode,write}
# L link in, D DMA in, W rxwr, R L|D rxrd by origin, Q rxrr, M mailbox word (32-bit)
D 0000D001000000009000000004
R D 0000D001000000009000000004
D 0000D002000000009000010004
R D 0000D002000000009000010004
D 0000D003000000009000020004
R D 0000D003000000009000020004
L 00000001111100018100000005
W 00000001111100018100000005
L 00000002111100028100000405
W 00000002111100028100000405
L 00000003000000008200000804
R L 00000003000000008200000804
L 00000004CAFEF00D800F000005
L 1234000500000000800F000004
Q 800F0000CAFEF00D1234000505
L 00000006AAAA0001800E000005
L 00000007AAAA0002800E000005
L 00000008AAAA0003800E000005
L 1234000900000000800F000804
Q 800F0008000000031234000905
L 0000000ABBBB0001800D000005
Q 0000000ABBBB0001800D000005
L 0000000BDEAD00018001000005
L 0000000C000000008002000004
L 0000000D111100038FF0001005
W 0000000D111100038FF0001005
L 0000000E000000007FF0002004
R L 0000000E000000007FF0002004
L 0000000F111100048100002005
W 0000000F111100048100002005
L 1234001000000000800F000404
Q 800F00040000000F1234001005
L 00000011111100058100003005
W 00000011111100058100003005
L 00000012000000008200004004
R L 00000012000000008200004004
L 0000001300000000800D000404
Q 0000001300000000800D000404
M AAAA0001
M AAAA0002
M AAAA0003

/* verif/tb_erx_core.sv */
`default_nettype none

module tb_erx_core;
   timeunit 1ns;
   timeprecision 1ps;
   import erx_pkg::*;

   localparam logic [11:0] LINK_ID = 12'h800;
   localparam int TIMEOUT = 200;
   localparam int DRAIN   = 50;

   logic          clk = 1'b0;
   logic          arst_n;
   logic          erx_access;
   logic [PW-1:0] erx_packet;
   logic          rx_rd_wait;
   logic          rx_wr_wait;
   logic          edma_access;
   logic [PW-1:0] edma_packet;
   logic          edma_wait;
   logic          rxwr_access;
   logic [PW-1:0] rxwr_packet;
   logic          rxwr_wait;
   logic          rxrd_access;
   logic [PW-1:0] rxrd_packet;
   logic          rxrd_wait;
   logic          rxrr_access;
   logic [PW-1:0] rxrr_packet;
   logic          rxrr_wait;
   logic          mbox_pop;
   logic [DW-1:0] mbox_data;
   logic          mbox_not_empty;

   // Stimulus and expected streams from the vector file
   logic [PW-1:0] link_q[$];
   logic [PW-1:0] dma_q[$];
   logic [PW-1:0] exp_wr[$];
   logic [PW-1:0] exp_rd_link[$];
   logic [PW-1:0] exp_rd_dma[$];
   logic [PW-1:0] exp_rr[$];
   logic [DW-1:0] exp_mbox[$];

   int errors   = 0;
   int timeouts = 0;
   int missing  = 0;

   erx_core #(
      .LINK_ID    (LINK_ID),
      .FIFO_DEPTH (4),
      .MBOX_DEPTH (4)
   ) dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .erx_access     (erx_access),
      .erx_packet     (erx_packet),
      .rx_rd_wait     (rx_rd_wait),
      .rx_wr_wait     (rx_wr_wait),
      .edma_access    (edma_access),
      .edma_packet    (edma_packet),
      .edma_wait      (edma_wait),
      .rxwr_access    (rxwr_access),
      .rxwr_packet    (rxwr_packet),
      .rxwr_wait      (rxwr_wait),
      .rxrd_access    (rxrd_access),
      .rxrd_packet    (rxrd_packet),
      .rxrd_wait      (rxrd_wait),
      .rxrr_access    (rxrr_access),
      .rxrr_packet    (rxrr_packet),
      .rxrr_wait      (rxrr_wait),
      .mbox_pop       (mbox_pop),
      .mbox_data      (mbox_data),
      .mbox_not_empty (mbox_not_empty)
   );

   // 20 ns period
   always #10 clk = ~clk;

   // ###################################################################
   // Vector loading and checking helpers
   // ###################################################################
   task automatic read_vectors;
      int            fd;
      int            n;
      string         tag;
      string         origin;
      string         rest;
      logic [PW-1:0] value;
      fd = $fopen("verif/erx_vectors.txt", "r");
      if (fd == 0) begin
         errors++;
         $display("Could not open verif/erx_vectors.txt");
         return;
      end
      while ($fscanf(fd, "%s", tag) == 1) begin
         if (tag == "#") begin
            n = $fgets(rest, fd);
         end else if (tag == "R") begin
            // Read queue entries carry their origin
            n = $fscanf(fd, "%s %h", origin, value);
            if (n != 2) begin
               errors++;
               $display("Malformed R record in the vector file");
            end else if (origin == "D") begin
               exp_rd_dma.push_back(value);
            end else begin
               exp_rd_link.push_back(value);
            end
         end else begin
            n = $fscanf(fd, "%h", value);
            if (n != 1) begin
               errors++;
               $display("Malformed %s record in the vector file", tag);
            end else begin
               case (tag)
                  "L":     link_q.push_back(value);
                  "D":     dma_q.push_back(value);
                  "W":     exp_wr.push_back(value);
                  "Q":     exp_rr.push_back(value);
                  "M":     exp_mbox.push_back(value[DW-1:0]);
                  default: begin
                     errors++;
                     $display("Unknown record tag %s in the vector file", tag);
                  end
               endcase
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic compare_packet(input string port, input logic [PW-1:0] got,
                                 input logic [PW-1:0] want);
      if (got !== want) begin
         errors++;
         $display("ERR %0t: %s got %h expected %h", $time, port, got, want);
      end
   endtask

   // Link source, starts and ends on a falling edge
   task automatic send_link(input logic [PW-1:0] pkt);
      int   cycles;
      logic stall;
      logic wr_side;
      // Writes and own traffic obey rx_wr_wait, foreign reads rx_rd_wait
      wr_side = pkt[WRITE_BIT] | (pkt[DSTADDR_LSB + ID_LSB +: ID_W] == LINK_ID);
      cycles = 0;
      stall = 1'b1;
      erx_packet = pkt;
      erx_access = 1'b1;
      while (stall && cycles < TIMEOUT) begin
         #1;
         stall = wr_side ? rx_wr_wait : rx_rd_wait;
         @(negedge clk);
         cycles++;
      end
      erx_access = 1'b0;
      if (stall) begin
         timeouts++;
         $display("Link packet %h was not taken within %0d cycles", pkt, TIMEOUT);
      end
   endtask

   // DMA read source, same timing as the link
   task automatic issue_dma_read(input logic [PW-1:0] pkt);
      int   cycles;
      logic stall;
      cycles = 0;
      stall = 1'b1;
      edma_packet = pkt;
      edma_access = 1'b1;
      while (stall && cycles < TIMEOUT) begin
         #1;
         stall = edma_wait;
         @(negedge clk);
         cycles++;
      end
      edma_access = 1'b0;
      if (stall) begin
         timeouts++;
         $display("DMA read %h was not taken within %0d cycles", pkt, TIMEOUT);
      end
   endtask

   task automatic wait_drained;
      int cycles;
      cycles = 0;
      while ((exp_wr.size() + exp_rd_link.size() + exp_rd_dma.size() + exp_rr.size()) != 0
             && cycles < TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      if (exp_wr.size() != 0) begin
         missing += exp_wr.size();
         $display("rxwr never delivered %0d expected packets", exp_wr.size());
      end
      if ((exp_rd_link.size() + exp_rd_dma.size()) != 0) begin
         missing += exp_rd_link.size() + exp_rd_dma.size();
         $display("rxrd never delivered %0d link and %0d DMA packets",
                  exp_rd_link.size(), exp_rd_dma.size());
      end
      if (exp_rr.size() != 0) begin
         missing += exp_rr.size();
         $display("rxrr never delivered %0d expected packets", exp_rr.size());
      end
   endtask

   // Pops each word once it shows, then expects an empty mailbox
   task automatic pop_mailbox;
      int            cycles;
      logic [DW-1:0] want;
      while (exp_mbox.size() != 0) begin
         want = exp_mbox.pop_front();
         cycles = 0;
         while (!mbox_not_empty && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
         end
         if (!mbox_not_empty) begin
            missing++;
            $display("Mailbox stayed empty while word %h was expected", want);
         end else begin
            if (mbox_data !== want) begin
               errors++;
               $display("ERR %0t: mbox_data got %h expected %h", $time, mbox_data, want);
            end
            mbox_pop = 1'b1;
            @(negedge clk);
            mbox_pop = 1'b0;
         end
      end
      if (mbox_not_empty) begin
         errors++;
         $display("ERR %0t: mbox_not_empty still high after the last pop", $time);
      end
   endtask

   // ###################################################################
   // Output sinks with random back-pressure
   // ###################################################################
   initial begin : sinks
      void'($urandom(26998));
      rxwr_wait = 1'b0;
      rxrd_wait = 1'b0;
      rxrr_wait = 1'b0;
      forever begin
         @(negedge clk);
         rxwr_wait = ($urandom % 10) < 3;
         rxrd_wait = ($urandom % 10) < 3;
         rxrr_wait = ($urandom % 10) < 3;
         // Sampled once the falling edge inputs have settled
         #1;
         if (rxwr_access && !rxwr_wait) begin
            if (exp_wr.size() == 0) begin
               errors++;
               $display("ERR %0t: rxwr extra packet %h", $time, rxwr_packet);
            end else begin
               compare_packet("rxwr", rxwr_packet, exp_wr.pop_front());
            end
         end
         // Link and DMA reads interleave, each stream keeps its order
         if (rxrd_access && !rxrd_wait) begin
            if (exp_rd_link.size() != 0 && rxrd_packet === exp_rd_link[0]) begin
               exp_rd_link.delete(0);
            end else if (exp_rd_dma.size() != 0 && rxrd_packet === exp_rd_dma[0]) begin
               exp_rd_dma.delete(0);
            end else begin
               errors++;
               $display("ERR %0t: rxrd packet %h is not the next link or DMA read",
                        $time, rxrd_packet);
            end
         end
         if (rxrr_access && !rxrr_wait) begin
            if (exp_rr.size() == 0) begin
               errors++;
               $display("ERR %0t: rxrr extra packet %h", $time, rxrr_packet);
            end else begin
               compare_packet("rxrr", rxrr_packet, exp_rr.pop_front());
            end
         end
      end
   end

   // ###################################################################
   // Main sequence
   // ###################################################################
   initial begin : main
      arst_n = 1'b0;
      erx_access = 1'b0;
      erx_packet = '0;
      edma_access = 1'b0;
      edma_packet = '0;
      mbox_pop = 1'b0;
      read_vectors();
      if (link_q.size() == 0) begin
         errors++;
         $display("No link packets were loaded from the vector file");
      end
      repeat (8) @(negedge clk);
      arst_n = 1'b1;
      repeat (2) @(negedge clk);
      // Both sources run side by side
      fork
         begin
            foreach (link_q[i]) begin
               if (timeouts == 0) send_link(link_q[i]);
            end
         end
         begin
            foreach (dma_q[i]) begin
               if (timeouts == 0) issue_dma_read(dma_q[i]);
            end
         end
      join
      wait_drained();
      pop_mailbox();
      // Anything arriving now is caught by the sinks as extra
      repeat (DRAIN) @(negedge clk);
      $display("Errors %0d, timeouts %0d, missing packets %0d", errors, timeouts, missing);
      if (errors == 0 && timeouts == 0 && missing == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hw/erx_core.sv */
`default_nettype none

module erx_core #(
   parameter logic [11:0] LINK_ID    = 12'h800,
   parameter int          FIFO_DEPTH = 4,
   parameter int          MBOX_DEPTH = 4
) (
   input  wire                    clk,
   input  wire                    arst_n,
   // Link input
   input  wire                    erx_access,
   input  wire [erx_pkg::PW-1:0]  erx_packet,
   output logic                   rx_rd_wait,
   output logic                   rx_wr_wait,
   // DMA read requests
   input  wire                    edma_access,
   input  wire [erx_pkg::PW-1:0]  edma_packet,
   output logic                   edma_wait,
   // Master write queue
   output logic                   rxwr_access,
   output logic [erx_pkg::PW-1:0] rxwr_packet,
   input  wire                    rxwr_wait,
   // Master read queue
   output logic                   rxrd_access,
   output logic [erx_pkg::PW-1:0] rxrd_packet,
   input  wire                    rxrd_wait,
   // Slave read-response queue
   output logic                   rxrr_access,
   output logic [erx_pkg::PW-1:0] rxrr_packet,
   input  wire                    rxrr_wait,
   // Mailbox read port
   input  wire                    mbox_pop,
   output logic [erx_pkg::DW-1:0] mbox_data,
   output logic                   mbox_not_empty
);
   import erx_pkg::*;

   // Arbiter to queues
   logic          wr_access;
   logic [PW-1:0] wr_packet;
   logic          wr_wait;
   logic          rd_access;
   logic [PW-1:0] rd_packet;
   logic          rd_wait;
   logic          rr_access;
   logic [PW-1:0] rr_packet;
   logic          rr_wait;
   // Register block
   logic          reg_access;
   logic [PW-1:0] reg_packet;
   logic          reg_wait;
   logic          cfg_access;
   logic [PW-1:0] cfg_packet;
   logic          cfg_wait;
   logic          erx_accepted;
   // Mailbox
   logic          mbox_access;
   logic [DW-1:0] mbox_word;
   logic          mbox_wait;
   logic [DW-1:0] mbox_count;

   // ###################################################################
   // Routing
   // ###################################################################
   erx_arbiter #(.LINK_ID(LINK_ID)) u_arbiter (
      .erx_access   (erx_access),
      .erx_packet   (erx_packet),
      .rx_rd_wait   (rx_rd_wait),
      .rx_wr_wait   (rx_wr_wait),
      .edma_access  (edma_access),
      .edma_packet  (edma_packet),
      .edma_wait    (edma_wait),
      .cfg_access   (cfg_access),
      .cfg_packet   (cfg_packet),
      .cfg_wait     (cfg_wait),
      .reg_access   (reg_access),
      .reg_packet   (reg_packet),
      .reg_wait     (reg_wait),
      .mbox_access  (mbox_access),
      .mbox_word    (mbox_word),
      .mbox_wait    (mbox_wait),
      .wr_access    (wr_access),
      .wr_packet    (wr_packet),
      .wr_wait      (wr_wait),
      .rd_access    (rd_access),
      .rd_packet    (rd_packet),
      .rd_wait      (rd_wait),
      .rr_access    (rr_access),
      .rr_packet    (rr_packet),
      .rr_wait      (rr_wait),
      .erx_accepted (erx_accepted)
   );

   // Registers and counters
   erx_cfg #(.LINK_ID(LINK_ID)) u_cfg (
      .clk          (clk),
      .arst_n       (arst_n),
      .reg_access   (reg_access),
      .reg_packet   (reg_packet),
      .reg_wait     (reg_wait),
      .erx_accepted (erx_accepted),
      .mbox_count   (mbox_count),
      .cfg_access   (cfg_access),
      .cfg_packet   (cfg_packet),
      .cfg_wait     (cfg_wait)
   );

   erx_mailbox #(.MBOX_DEPTH(MBOX_DEPTH)) u_mailbox (
      .clk            (clk),
      .arst_n         (arst_n),
      .mbox_access    (mbox_access),
      .mbox_word      (mbox_word),
      .mbox_wait      (mbox_wait),
      .mbox_pop       (mbox_pop),
      .mbox_data      (mbox_data),
      .mbox_not_empty (mbox_not_empty),
      .mbox_count     (mbox_count)
   );

   // ###################################################################
   // Output queues
   // ###################################################################
   erx_fifo #(.DEPTH(FIFO_DEPTH)) u_wr_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_access  (wr_access),
      .in_packet  (wr_packet),
      .in_wait    (wr_wait),
      .out_access (rxwr_access),
      .out_packet (rxwr_packet),
      .out_wait   (rxwr_wait)
   );

   erx_fifo #(.DEPTH(FIFO_DEPTH)) u_rd_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_access  (rd_access),
      .in_packet  (rd_packet),
      .in_wait    (rd_wait),
      .out_access (rxrd_access),
      .out_packet (rxrd_packet),
      .out_wait   (rxrd_wait)
   );

   erx_fifo #(.DEPTH(FIFO_DEPTH)) u_rr_fifo (
      .clk        (clk),
      .arst_n     (arst_n),
      .in_access  (rr_access),
      .in_packet  (rr_packet),
      .in_wait    (rr_wait),
      .out_access (rxrr_access),
      .out_packet (rxrr_packet),
      .out_wait   (rxrr_wait)
   );

endmodule

`default_nettype wire

/* hw/erx_mailbox.sv */
`default_nettype none

module erx_mailbox #(
   parameter int MBOX_DEPTH = 4
) (
   input  wire                    clk,
   input  wire                    arst_n,
   // Push from link writes
   input  wire                    mbox_access,
   input  wire [erx_pkg::DW-1:0]  mbox_word,
   output logic                   mbox_wait,
   // Host read side
   input  wire                    mbox_pop,
   output logic [erx_pkg::DW-1:0] mbox_data,
   output logic                   mbox_not_empty,
   output logic [erx_pkg::DW-1:0] mbox_count
);
   import erx_pkg::*;

   localparam int PTR_W = (MBOX_DEPTH > 1) ? $clog2(MBOX_DEPTH) : 1;
   localparam int CNT_W = $clog2(MBOX_DEPTH + 1);

   logic [DW-1:0]    mem [MBOX_DEPTH];
   logic [PTR_W-1:0] wptr;
   logic [PTR_W-1:0] rptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;
   logic             pop;

   assign full           = (count == CNT_W'(MBOX_DEPTH));
   assign mbox_wait      = full;
   assign mbox_not_empty = (count != '0);
   assign mbox_data      = mem[rptr];
   assign mbox_count     = DW'(count);
   assign push           = mbox_access & ~full;
   // Pop on empty mailbox ignored
   assign pop            = mbox_pop & mbox_not_empty;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wptr <= (wptr == PTR_W'(MBOX_DEPTH - 1)) ? '0 : wptr + 1'b1;
         end
         if (pop) begin
            rptr <= (rptr == PTR_W'(MBOX_DEPTH - 1)) ? '0 : rptr + 1'b1;
         end
         count <= count + CNT_W'(push) - CNT_W'(pop);
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr] <= mbox_word;
      end
   end

   // Fill level never passes the depth
   a_no_push_full: assert property (@(posedge clk) disable iff (!arst_n)
      count <= CNT_W'(MBOX_DEPTH))
      else $error("erx_mailbox: push landed while full");

endmodule

`default_nettype wire

/* hw/erx_cfg.sv */
`default_nettype none

module erx_cfg #(
   parameter logic [11:0] LINK_ID = 12'h800
) (
   input  wire                    clk,
   input  wire                    arst_n,
   // Register requests from the arbiter
   input  wire                    reg_access,
   input  wire [erx_pkg::PW-1:0]  reg_packet,
   output logic                   reg_wait,
   // Status inputs
   input  wire                    erx_accepted,
   input  wire [erx_pkg::DW-1:0]  mbox_count,
   // Read responses
   output logic                   cfg_access,
   output logic [erx_pkg::PW-1:0] cfg_packet,
   input  wire                    cfg_wait
);
   import erx_pkg::*;

   cfg_state_e    state;
   logic [DW-1:0] cfg_q;
   logic [DW-1:0] pktcnt_q;
   logic [DW-1:0] rd_value;
   logic [AW-1:0] req_dstaddr;
   logic [AW-1:0] req_srcaddr;
   logic          req_write;
   reg_e          req_reg;
   logic          accept;

   // ###################################################################
   // Request decode
   // ###################################################################
   assign req_write   = reg_packet[WRITE_BIT];
   assign req_dstaddr = reg_packet[DSTADDR_LSB +: AW];
   assign req_srcaddr = reg_packet[SRCADDR_LSB +: AW];
   assign req_reg     = reg_e'(req_dstaddr[REG_LSB +: REG_W]);

   // No new request while a response waits
   assign cfg_access = (state == cfg_resp);
   assign reg_wait   = cfg_access;
   assign accept     = reg_access & ~reg_wait;

   // Readback mux
   always_comb begin
      case (req_reg)
         reg_cfg:      rd_value = cfg_q;
         reg_pktcnt:   rd_value = pktcnt_q;
         reg_mbox_cnt: rd_value = mbox_count;
         default:      rd_value = '0;
      endcase
   end

   // ###################################################################
   // Registers and FSM
   // ###################################################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= cfg_idle;
         cfg_q    <= '0;
         pktcnt_q <= '0;
      end else begin
         if (erx_accepted) begin
            pktcnt_q <= pktcnt_q + 1'b1;
         end
         // Scratch register is the only writable word
         if (accept && req_write && (req_reg == reg_cfg)) begin
            cfg_q <= reg_packet[DATA_LSB +: DW];
         end
         case (state)
            cfg_idle: if (accept && !req_write) state <= cfg_resp;
            cfg_resp: if (!cfg_wait) state <= cfg_idle;
            default:  state <= cfg_idle;
         endcase
      end
   end

   // Response packet, addresses swapped
   always_ff @(posedge clk) begin
      if (accept && !req_write) begin
         cfg_packet[WRITE_BIT]                    <= 1'b1;
         cfg_packet[DATAMODE_LSB +: DATAMODE_W]   <= reg_packet[DATAMODE_LSB +: DATAMODE_W];
         cfg_packet[CTRLMODE_LSB +: CTRLMODE_W]   <= reg_packet[CTRLMODE_LSB +: CTRLMODE_W];
         cfg_packet[DSTADDR_LSB +: AW]            <= req_srcaddr;
         cfg_packet[DATA_LSB +: DW]               <= rd_value;
         cfg_packet[SRCADDR_LSB +: AW]            <= req_dstaddr;
      end
   end

   // Pending response held until the rr queue takes it
   a_resp_hold: assert property (@(posedge clk) disable iff (!arst_n)
      cfg_access && cfg_wait |=> cfg_access && $stable(cfg_packet))
      else $error("erx_cfg: response changed under back-pressure");

   // Arbiter only forwards this link's own register traffic
   a_own_id: assert property (@(posedge clk) disable iff (!arst_n)
      reg_access |-> (req_dstaddr[ID_LSB +: ID_W] == LINK_ID))
      else $error("erx_cfg: register access for foreign link id");

endmodule

`default_nettype wire

/* hw/erx_arbiter.sv */
`default_nettype none

module erx_arbiter #(
   parameter logic [11:0] LINK_ID = 12'h800
) (
   // Link input
   input  wire                    erx_access,
   input  wire [erx_pkg::PW-1:0]  erx_packet,
   output logic                   rx_rd_wait,
   output logic                   rx_wr_wait,
   // DMA read requests
   input  wire                    edma_access,
   input  wire [erx_pkg::PW-1:0]  edma_packet,
   output logic                   edma_wait,
   // Register read responses
   input  wire                    cfg_access,
   input  wire [erx_pkg::PW-1:0]  cfg_packet,
   output logic                   cfg_wait,
   // Register block
   output logic                   reg_access,
   output logic [erx_pkg::PW-1:0] reg_packet,
   input  wire                    reg_wait,
   // Mailbox
   output logic                   mbox_access,
   output logic [erx_pkg::DW-1:0] mbox_word,
   input  wire                    mbox_wait,
   // Output queues
   output logic                   wr_access,
   output logic [erx_pkg::PW-1:0] wr_packet,
   input  wire                    wr_wait,
   output logic                   rd_access,
   output logic [erx_pkg::PW-1:0] rd_packet,
   input  wire                    rd_wait,
   output logic                   rr_access,
   output logic [erx_pkg::PW-1:0] rr_packet,
   input  wire                    rr_wait,
   // One pulse per link packet taken
   output logic                   erx_accepted
);
   import erx_pkg::*;

   // ###################################################################
   // Link packet decode
   // ###################################################################
   logic          erx_write;
   logic [AW-1:0] erx_dstaddr;
   logic          erx_own;
   grp_e          erx_grp;
   logic          to_wr;
   logic          to_rd;
   logic          to_reg;
   logic          to_mbox;
   logic          to_rr;
   logic          wr_side;

   assign erx_write   = erx_packet[WRITE_BIT];
   assign erx_dstaddr = erx_packet[DSTADDR_LSB +: AW];
   assign erx_own     = (erx_dstaddr[ID_LSB +: ID_W] == LINK_ID);
   assign erx_grp     = grp_e'(erx_dstaddr[GRP_LSB +: GRP_W]);

   // Target select
   assign to_wr   = erx_access & erx_write & ~erx_own;
   assign to_rd   = erx_access & ~erx_write & ~erx_own;
   assign to_reg  = erx_access & erx_own & (erx_grp == grp_regs);
   assign to_mbox = erx_access & erx_own & erx_write & (erx_grp == grp_mbox);
   assign to_rr   = erx_access & erx_own & (erx_grp == grp_rr);
   // Writes and own traffic obey rx_wr_wait, other reads rx_rd_wait
   assign wr_side = erx_write | erx_own;

   // ###################################################################
   // Write side targets
   // ###################################################################
   // Held off while a register response owns the rr queue
   assign wr_access   = to_wr & ~cfg_access;
   assign wr_packet   = erx_packet;
   assign reg_access  = to_reg & ~cfg_access;
   assign reg_packet  = erx_packet;
   assign mbox_access = to_mbox & ~cfg_access;
   assign mbox_word   = erx_packet[DATA_LSB +: DW];

   // Read queue, link before DMA
   assign rd_access = to_rd | edma_access;
   assign rd_packet = to_rd ? erx_packet : edma_packet;

   // Read-response queue, register response before link
   assign rr_access = cfg_access | to_rr;
   assign rr_packet = cfg_access ? cfg_packet : erx_packet;

   // ###################################################################
   // Waits
   // ###################################################################
   assign rx_rd_wait = rd_wait;
   assign rx_wr_wait = cfg_access |
                       (to_wr & wr_wait) |
                       (to_reg & reg_wait) |
                       (to_mbox & mbox_wait) |
                       (to_rr & rr_wait);
   assign edma_wait  = rd_wait | to_rd;
   assign cfg_wait   = rr_wait;

   // Counted for every transfer, dropped own packets too
   assign erx_accepted = erx_access & (wr_side ? ~rx_wr_wait : ~rx_rd_wait);

endmodule

`default_nettype wire

/* hw/erx_fifo.sv */
`default_nettype none

module erx_fifo #(
   parameter int DEPTH = 4
) (
   input  wire                    clk,
   input  wire                    arst_n,
   // Push side
   input  wire                    in_access,
   input  wire [erx_pkg::PW-1:0]  in_packet,
   output logic                   in_wait,
   // Pop side
   output logic                   out_access,
   output logic [erx_pkg::PW-1:0] out_packet,
   input  wire                    out_wait
);
   import erx_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [PW-1:0]    mem [DEPTH];
   logic [PTR_W-1:0] wptr;
   logic [PTR_W-1:0] rptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;
   logic             pop;

   assign full       = (count == CNT_W'(DEPTH));
   assign out_access = (count != '0);
   assign out_packet = mem[rptr];
   assign pop        = out_access & ~out_wait;
   // Full queue still takes a word when the head leaves this cycle
   assign in_wait    = full & out_wait;
   assign push       = in_access & ~in_wait;

   // Pointers and fill count
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wptr  <= '0;
         rptr  <= '0;
         count <= '0;
      end else begin
         if (push) begin
            wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
         end
         if (pop) begin
            rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wptr] <= in_packet;
      end
   end

   a_count_max: assert property (@(posedge clk) disable iff (!arst_n)
      count <= CNT_W'(DEPTH))
      else $error("erx_fifo: fill count above depth");

endmodule

`default_nettype wire

/* hw/erx_pkg.sv */
`default_nettype none

package erx_pkg;

   // ###################################################################
   // Packet layout
   // ###################################################################
   localparam int PW = 104;
   localparam int AW = 32;
   localparam int DW = 32;

   // Field positions, LSB of each field
   localparam int WRITE_BIT    = 0;
   localparam int DATAMODE_LSB = 1;
   localparam int DATAMODE_W   = 2;
   localparam int CTRLMODE_LSB = 3;
   localparam int CTRLMODE_W   = 5;
   localparam int DSTADDR_LSB  = 8;
   localparam int DATA_LSB     = 40;
   localparam int SRCADDR_LSB  = 72;

   // Subfields of dstaddr
   localparam int ID_LSB  = 20;
   localparam int ID_W    = 12;
   localparam int GRP_LSB = 16;
   localparam int GRP_W   = 4;
   localparam int REG_LSB = 2;
   localparam int REG_W   = 2;

   // ###################################################################
   // Encodings
   // ###################################################################
   // Address groups for own traffic, anything else is ordinary
   typedef enum logic [GRP_W-1:0] {
      grp_rr   = 4'hD,
      grp_mbox = 4'hE,
      grp_regs = 4'hF
   } grp_e;

   // Register word offsets
   typedef enum logic [REG_W-1:0] {
      reg_cfg      = 2'd0,
      reg_pktcnt   = 2'd1,
      reg_mbox_cnt = 2'd2
   } reg_e;

   // Register block FSM
   typedef enum logic {
      cfg_idle = 1'b0,
      cfg_resp = 1'b1
   } cfg_state_e;

endpackage

`default_nettype wire
